//--- hw/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    localparam int QTR_CYCLES = 2;   // CLK cycles per quarter of scl
    localparam int QCNT_W     = (QTR_CYCLES > 1) ? $clog2(QTR_CYCLES) : 1;

    localparam logic [3:0] DEV_CODE = 4'b1010;

    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;
    localparam int BLK_W  = ADDR_W - DATA_W;

    // a single-byte read ends with a not-acknowledge
    localparam logic RD_ACK = 1'b0;

    // one-hot sequencer states
    localparam int NST = 10;
    localparam logic [NST-1:0] ST_IDLE   = 10'b00_0000_0001;
    localparam logic [NST-1:0] ST_START  = 10'b00_0000_0010;
    localparam logic [NST-1:0] ST_CTRL   = 10'b00_0000_0100;
    localparam logic [NST-1:0] ST_ADDR   = 10'b00_0000_1000;
    localparam logic [NST-1:0] ST_DATA   = 10'b00_0001_0000;
    localparam logic [NST-1:0] ST_RSTART = 10'b00_0010_0000;
    localparam logic [NST-1:0] ST_RCTRL  = 10'b00_0100_0000;
    localparam logic [NST-1:0] ST_READ   = 10'b00_1000_0000;
    localparam logic [NST-1:0] ST_STOP   = 10'b01_0000_0000;
    localparam logic [NST-1:0] ST_HSK    = 10'b10_0000_0000;

    typedef union packed {
        logic [DATA_W-1:0] raw;        // as shifted onto the bus
        struct packed {
            logic [3:0]       dev_code;
            logic [BLK_W-1:0] block;   // addr[10:8]
            logic             rw;
        } fields;
    } ctrl_byte_u;

endpackage

`default_nettype wire

//--- hw/i2c_byte_tx.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_tx import eeprom_pkg::*;
(
    input  wire              CLK,
    input  wire              RESET,
    input  wire              q_low_mid,
    input  wire              q_high_mid,
    input  wire              tx_go,
    input  wire [DATA_W-1:0] tx_byte,
    input  wire              sda_in,
    output logic             tx_low,
    output logic             tx_done,
    output logic             tx_nack
);

    logic [DATA_W-1:0] shreg;
    logic [3:0]        bit_cnt;   // bits started so far
    logic              active;
    logic              data_bit;

    assign data_bit = (bit_cnt < 4'(DATA_W));

    always_ff @(posedge CLK)
    begin
        if (tx_go)
            shreg <= tx_byte;
        else if (active && q_low_mid && data_bit)
            shreg <= {shreg[DATA_W-2:0], 1'b0};
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active  <= 1'b0;
            bit_cnt <= '0;
            tx_low  <= 1'b0;
            tx_done <= 1'b0;
            tx_nack <= 1'b0;
        end
        else
        begin
            tx_done <= 1'b0;
            if (tx_go)
            begin
                active  <= 1'b1;
                bit_cnt <= '0;
            end
            else if (active && q_low_mid)
            begin
                tx_low  <= data_bit && !shreg[DATA_W-1];   // ninth bit released
                bit_cnt <= bit_cnt + 4'd1;
            end
            else if (active && q_high_mid && bit_cnt == 4'(DATA_W + 1))
            begin
                tx_nack <= sda_in;   // high means nobody acknowledged
                tx_done <= 1'b1;
                active  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/i2c_byte_rx.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_rx import eeprom_pkg::*;
(
    input  wire               CLK,
    input  wire               RESET,
    input  wire               q_low_mid,
    input  wire               q_high_mid,
    input  wire               rx_go,
    input  wire               sda_in,
    output logic              rx_low,
    output logic              rx_done,
    output logic [DATA_W-1:0] rx_byte
);

    logic [3:0] bit_cnt;   // bits sampled so far
    logic       active;
    logic       data_bit;

    assign data_bit = (bit_cnt < 4'(DATA_W));

    // msb arrives first
    always_ff @(posedge CLK)
    begin
        if (active && q_high_mid && data_bit)
            rx_byte <= {rx_byte[DATA_W-2:0], sda_in};
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active  <= 1'b0;
            bit_cnt <= '0;
            rx_low  <= 1'b0;
            rx_done <= 1'b0;
        end
        else
        begin
            rx_done <= 1'b0;
            if (q_low_mid)
                rx_low <= active && !data_bit && RD_ACK;   // master ack bit
            if (rx_go)
            begin
                active  <= 1'b1;
                bit_cnt <= '0;
            end
            else if (active && q_high_mid)
            begin
                if (data_bit)
                    bit_cnt <= bit_cnt + 4'd1;
                else
                begin
                    rx_done <= 1'b1;
                    active  <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/eeprom_seq.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_seq import eeprom_pkg::*;
(
    input  wire               CLK,
    input  wire               RESET,
    input  wire               req,
    input  wire               wr,
    input  wire  [ADDR_W-1:0] addr,
    input  wire  [DATA_W-1:0] wdata,
    input  wire               sda_in,
    output logic              ack,
    output logic [DATA_W-1:0] rdata,
    output logic              nack_err,
    output logic              scl,
    output logic              sda_low,
    output logic              q_low_mid,
    output logic              q_high_mid,
    output logic              tx_go,
    output logic [DATA_W-1:0] tx_byte,
    output logic              rx_go,
    input  wire               tx_done,
    input  wire               tx_nack,
    input  wire               tx_low,
    input  wire               rx_done,
    input  wire  [DATA_W-1:0] rx_byte,
    input  wire               rx_low
);

    logic [NST-1:0]    state;
    logic [1:0]        phase;   // quarter of the bit, scl high in 2 and 3
    logic [QCNT_W-1:0] qcnt;
    logic              q_last;
    logic              busy;
    logic              seq_low;
    ctrl_byte_u        cb;

    assign busy       = (state != ST_IDLE) && (state != ST_HSK);
    assign q_last     = (qcnt == QCNT_W'(QTR_CYCLES - 1));
    assign q_low_mid  = busy && q_last && (phase == 2'd0);
    assign q_high_mid = busy && q_last && (phase == 2'd2);
    assign scl        = !busy || phase[1];   // parked high between transfers
    assign sda_low    = seq_low || tx_low || rx_low;

    always_ff @(posedge CLK)
    begin
        if (RESET || !busy)
        begin
            phase <= 2'd0;
            qcnt  <= '0;
        end
        else if (q_last)
        begin
            phase <= phase + 2'd1;
            qcnt  <= '0;
        end
        else
            qcnt <= qcnt + 1'b1;
    end

    always_comb
    begin
        cb.fields.dev_code = DEV_CODE;
        cb.fields.block    = addr[ADDR_W-1:DATA_W];
        cb.fields.rw       = (state == ST_RCTRL);
    end

    always_comb
    begin
        case (state)
            ST_ADDR: tx_byte = addr[DATA_W-1:0];
            ST_DATA: tx_byte = wdata;
            default: tx_byte = cb.raw;   // write or read control byte
        endcase
    end

    // start: released while scl low, pulled at mid high
    // stop: pulled while scl low, released at mid high
    always_ff @(posedge CLK)
    begin
        if (RESET)
            seq_low <= 1'b0;
        else if (q_low_mid)
            seq_low <= (state == ST_STOP);
        else if (q_high_mid)
            seq_low <= (state == ST_START) || (state == ST_RSTART);
    end

    always_ff @(posedge CLK)
    begin
        if (state == ST_READ && rx_done)
            rdata <= rx_byte;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= ST_IDLE;
            ack      <= 1'b0;
            nack_err <= 1'b0;
            tx_go    <= 1'b0;
            rx_go    <= 1'b0;
        end
        else
        begin
            tx_go <= 1'b0;
            rx_go <= 1'b0;
            if (tx_done && tx_nack)
            begin
                nack_err <= 1'b1;   // slave silent, finish with a stop
                state    <= ST_STOP;
            end
            else
            begin
                case (state)
                    ST_IDLE:
                    begin
                        if (req && sda_in)   // wait for a free bus
                        begin
                            nack_err <= 1'b0;
                            state    <= ST_START;
                        end
                    end
                    ST_START:
                    begin
                        if (q_high_mid)
                        begin
                            tx_go <= 1'b1;
                            state <= ST_CTRL;
                        end
                    end
                    ST_CTRL:
                    begin
                        if (tx_done)
                        begin
                            tx_go <= 1'b1;
                            state <= ST_ADDR;
                        end
                    end
                    ST_ADDR:
                    begin
                        if (tx_done && wr)
                        begin
                            tx_go <= 1'b1;
                            state <= ST_DATA;
                        end
                        else if (tx_done)
                            state <= ST_RSTART;
                    end
                    ST_DATA:
                    begin
                        if (tx_done)
                            state <= ST_STOP;
                    end
                    ST_RSTART:
                    begin
                        if (q_high_mid)
                        begin
                            tx_go <= 1'b1;
                            state <= ST_RCTRL;
                        end
                    end
                    ST_RCTRL:
                    begin
                        if (tx_done)
                        begin
                            rx_go <= 1'b1;
                            state <= ST_READ;
                        end
                    end
                    ST_READ:
                    begin
                        if (rx_done)
                            state <= ST_STOP;
                    end
                    ST_STOP:
                    begin
                        if (q_high_mid)
                        begin
                            ack   <= 1'b1;
                            state <= ST_HSK;
                        end
                    end
                    ST_HSK:
                    begin
                        if (!req)
                        begin
                            ack   <= 1'b0;
                            state <= ST_IDLE;
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/eeprom_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl import eeprom_pkg::*;
(
    input  wire               CLK,
    input  wire               RESET,
    input  wire               req,
    input  wire               wr,
    input  wire  [ADDR_W-1:0] addr,
    input  wire  [DATA_W-1:0] wdata,
    output logic              ack,
    output logic [DATA_W-1:0] rdata,
    output logic              nack_err,
    output logic              scl,
    output logic              sda_low,
    input  wire               sda_in
);

    logic              q_low_mid;
    logic              q_high_mid;
    logic              tx_go;
    logic [DATA_W-1:0] tx_byte;
    logic              tx_done;
    logic              tx_nack;
    logic              tx_low;
    logic              rx_go;
    logic              rx_done;
    logic [DATA_W-1:0] rx_byte;
    logic              rx_low;

    eeprom_seq u_seq (
        .CLK(CLK), .RESET(RESET),
        .req(req), .wr(wr), .addr(addr), .wdata(wdata), .sda_in(sda_in),
        .ack(ack), .rdata(rdata), .nack_err(nack_err),
        .scl(scl), .sda_low(sda_low),
        .q_low_mid(q_low_mid), .q_high_mid(q_high_mid),
        .tx_go(tx_go), .tx_byte(tx_byte), .rx_go(rx_go),
        .tx_done(tx_done), .tx_nack(tx_nack), .tx_low(tx_low),
        .rx_done(rx_done), .rx_byte(rx_byte), .rx_low(rx_low)
    );

    i2c_byte_tx u_tx (
        .CLK(CLK), .RESET(RESET),
        .q_low_mid(q_low_mid), .q_high_mid(q_high_mid),
        .tx_go(tx_go), .tx_byte(tx_byte), .sda_in(sda_in),
        .tx_low(tx_low), .tx_done(tx_done), .tx_nack(tx_nack)
    );

    i2c_byte_rx u_rx (
        .CLK(CLK), .RESET(RESET),
        .q_low_mid(q_low_mid), .q_high_mid(q_high_mid),
        .rx_go(rx_go), .sda_in(sda_in),
        .rx_low(rx_low), .rx_done(rx_done), .rx_byte(rx_byte)
    );

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock
(
    output logic CLK,
    output logic RESET
);

    initial
    begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;   // 10 ns period
    end

    initial
    begin
        RESET = 1'b1;
        repeat (16) @(posedge CLK);
        #1 RESET = 1'b0;
    end

endmodule

`default_nettype wire

//--- tb/eeprom_model.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_model import eeprom_pkg::*;
(
    input  wire         scl,
    input  wire         sda,
    input  wire         refuse_ctrl,
    output logic        sda_low,
    output logic [31:0] stop_count
);

    logic [DATA_W-1:0] mem [0:2**ADDR_W-1];
    logic [DATA_W-1:0] shreg;
    logic [DATA_W-1:0] txreg;
    logic [ADDR_W-1:0] ptr;
    logic [BLK_W-1:0]  blk;
    logic              active;
    logic              reading;
    logic              go_read;
    logic              scl_q;
    logic              sda_q;
    int                bit_cnt;    // scl rises in the current byte
    int                byte_idx;
    ctrl_byte_u        cb;

    initial
    begin
        for (int i = 0; i < 2**ADDR_W; i++)
            mem[i] = 8'(i ^ (i >> 3) ^ 'h5a);
        sda_low    = 1'b0;
        stop_count = '0;
        active     = 1'b0;
        reading    = 1'b0;
        go_read    = 1'b0;
        bit_cnt    = 0;
        byte_idx   = 0;
        ptr        = '0;
        blk        = '0;
        shreg      = '0;
        txreg      = '0;
        scl_q      = 1'b1;
        sda_q      = 1'b1;
        forever
        begin
            @(scl or sda);
            if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b1 && sda === 1'b0)
            begin
                active   = 1'b1;   // start or repeated start
                reading  = 1'b0;
                bit_cnt  = 0;
                byte_idx = 0;
                sda_low  = 1'b0;
            end
            else if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b0 && sda === 1'b1)
            begin
                active     = 1'b0;   // stop
                reading    = 1'b0;
                sda_low    = 1'b0;
                stop_count = stop_count + 1;
            end
            else if (scl_q === 1'b0 && scl === 1'b1 && active)
            begin
                if (!reading && bit_cnt < 8)
                    shreg = {shreg[6:0], sda};
                if (reading && bit_cnt == 8 && sda)
                    active = 1'b0;   // master nack, wait for stop
                bit_cnt = bit_cnt + 1;
            end
            else if (scl_q === 1'b1 && scl === 1'b0)
            begin
                if (!active)
                    sda_low = 1'b0;
                else if (bit_cnt == 8 && reading)
                    sda_low = 1'b0;
                else if (bit_cnt == 8)
                begin
                    sda_low = 1'b1;
                    if (byte_idx == 0)
                    begin
                        cb.raw = shreg;
                        if (cb.fields.dev_code != DEV_CODE || refuse_ctrl)
                        begin
                            sda_low = 1'b0;
                            active  = 1'b0;
                        end
                        blk     = cb.fields.block;
                        go_read = cb.fields.rw;
                    end
                    else if (byte_idx == 1)
                        ptr = {blk, shreg};
                    else if (byte_idx == 2)
                        mem[ptr] = shreg;
                    byte_idx = byte_idx + 1;
                end
                else if (bit_cnt == 9)
                begin
                    bit_cnt = 0;
                    sda_low = 1'b0;
                    if (go_read)
                    begin
                        go_read = 1'b0;
                        reading = 1'b1;
                        txreg   = mem[ptr];
                        sda_low = !txreg[7];
                    end
                end
                else if (reading && bit_cnt < 8)
                    sda_low = !txreg[7-bit_cnt];
            end
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule

`default_nettype wire

//--- tb/eeprom_ctrl_assert.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_assert import eeprom_pkg::*;
(
    input wire              CLK,
    input wire              RESET,
    input wire              req,
    input wire              ack,
    input wire [DATA_W-1:0] rdata,
    input wire              nack_err,
    input wire              scl,
    input wire              sda_low
);

    ack_needs_req: assert property (@(posedge CLK) disable iff (RESET)
        $rose(ack) |-> $past(req))
        else $error("ack rose without a pending request");

    result_stable: assert property (@(posedge CLK) disable iff (RESET)
        (ack && $past(ack)) |-> ($stable(rdata) && $stable(nack_err)))
        else $error("result changed while ack was high");

    // no request pending, bus parked
    bus_idle: assert property (@(posedge CLK) disable iff (RESET)
        (!req && !ack) |-> (scl && !sda_low))
        else $error("bus not idle between transfers");

endmodule

bind eeprom_ctrl eeprom_ctrl_assert u_assert (
    .CLK(CLK), .RESET(RESET), .req(req), .ack(ack), .rdata(rdata),
    .nack_err(nack_err), .scl(scl), .sda_low(sda_low)
);

`default_nettype wire

//--- tb/tb_eeprom_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_ctrl import eeprom_pkg::*; ();

    localparam int N_XFERS     = 252;
    localparam int READ_BITS   = 39;
    localparam int BIT_CYC     = 4 * QTR_CYCLES;
    localparam int XFER_LIMIT  = READ_BITS * BIT_CYC * 2;
    localparam int HOLD_CYC    = XFER_LIMIT;   // long enough for a whole extra transfer
    localparam int WATCHDOG_NS = (N_XFERS * XFER_LIMIT + HOLD_CYC + 16) * 10;

    logic              CLK;
    logic              RESET;
    logic              req;
    logic              wr;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              ack;
    logic [DATA_W-1:0] rdata;
    logic              nack_err;
    logic              scl;
    logic              sda_low;
    wire               sda_in;
    logic              model_low;
    logic              refuse;
    logic [31:0]       stop_count;
    logic [DATA_W-1:0] ref_mem [0:2**ADDR_W-1];
    int                seed = 32'h6c83;
    logic              fail_shown = 1'b0;
    logic              run_ok = 1'b0;

    assign sda_in = !(sda_low || model_low);   // open-drain line with pull-up

    tb_clock u_clock (.CLK(CLK), .RESET(RESET));

    eeprom_ctrl uut (
        .CLK(CLK), .RESET(RESET), .req(req), .wr(wr), .addr(addr), .wdata(wdata),
        .ack(ack), .rdata(rdata), .nack_err(nack_err),
        .scl(scl), .sda_low(sda_low), .sda_in(sda_in)
    );

    eeprom_model u_model (
        .scl(scl), .sda(sda_in), .refuse_ctrl(refuse),
        .sda_low(model_low), .stop_count(stop_count)
    );

    function automatic logic [DATA_W-1:0] fill_value(input int a);
        return 8'(a ^ (a >> 3) ^ 'h5a);
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        fail_shown = 1'b1;
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_rdata(input string name, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] act);
        if (act !== exp)
            fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_nack(input string name, input logic exp, input logic act);
        if (act !== exp)
            fail_run($sformatf("Mismatch %s: expected nack_err %b, actual %b", name, exp, act));
    endtask

    task automatic check_handshake(input string name, input logic ok, input string what);
        if (!ok)
            fail_run($sformatf("%s: %s", name, what));
    endtask

    task automatic do_xfer(input string name, input logic w, input logic [ADDR_W-1:0] a,
                           input logic [DATA_W-1:0] d, input int hold,
                           output logic [DATA_W-1:0] rd, output logic ne);
        int          cnt;
        logic [31:0] stops0;
        @(posedge CLK);
        #1;
        stops0 = stop_count;
        req    = 1'b1;
        wr     = w;
        addr   = a;
        wdata  = d;
        cnt    = 0;
        while (ack !== 1'b1 && cnt < XFER_LIMIT)
        begin
            @(posedge CLK);
            #1;
            cnt++;
        end
        check_handshake(name, ack === 1'b1, "ack never rose");
        rd = rdata;
        ne = nack_err;
        repeat (hold)
        begin
            @(posedge CLK);
            #1;
        end
        check_handshake(name, ack === 1'b1, "ack dropped while req was still high");
        check_handshake(name, stop_count == stops0 + 1, "wrong number of bus transfers");
        req = 1'b0;
        cnt = 0;
        while (ack !== 1'b0 && cnt < 4)
        begin
            @(posedge CLK);
            #1;
            cnt++;
        end
        check_handshake(name, ack === 1'b0, "ack did not drop after req fell");
    endtask

    task automatic write_byte(input string name, input logic [ADDR_W-1:0] a,
                              input logic [DATA_W-1:0] d);
        logic [DATA_W-1:0] rd;
        logic              ne;
        do_xfer(name, 1'b1, a, d, 0, rd, ne);
        check_nack(name, 1'b0, ne);
        ref_mem[a] = d;
    endtask

    task automatic read_check(input string name, input logic [ADDR_W-1:0] a);
        logic [DATA_W-1:0] rd;
        logic              ne;
        do_xfer(name, 1'b0, a, '0, 0, rd, ne);
        check_nack(name, 1'b0, ne);
        check_rdata(name, ref_mem[a], rd);
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        fail_shown = 1'b1;
        $display("CHECKS FAILED");
        $fatal(1);
    end

    // catches a stop from a failed assertion
    final
    begin
        if (!run_ok && !fail_shown)
            $display("CHECKS FAILED");
    end

    initial
    begin
        logic [ADDR_W-1:0] addrs [16];
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] v0;
        logic [DATA_W-1:0] old;
        logic [DATA_W-1:0] rd;
        logic [DATA_W-1:0] low_b;
        logic              ne;
        logic [31:0]       r;
        req    = 1'b0;
        wr     = 1'b0;
        addr   = '0;
        wdata  = '0;
        refuse = 1'b0;
        for (int i = 0; i < 2**ADDR_W; i++)
            ref_mem[i] = fill_value(i);
        while (RESET !== 1'b0)
            @(posedge CLK);

        for (int i = 0; i < 16; i++)   // write then read back
        begin
            r        = $random(seed);
            addrs[i] = r[ADDR_W-1:0];
            write_byte("write", addrs[i], r[31:24]);
        end
        for (int i = 0; i < 16; i++)
            read_check("read back", addrs[i]);

        r     = $random(seed);
        low_b = r[7:0];
        v0    = r[15:8];
        for (int k = 0; k < 8; k++)   // same low byte, every block
            write_byte("block write", {3'(k), low_b}, v0 + 8'(k * 37));
        for (int k = 0; k < 8; k++)
        begin
            a = {3'(k), low_b};
            check_rdata("block in model", ref_mem[a], u_model.mem[a]);
            read_check("block read", a);
        end

        r      = $random(seed);
        a      = r[ADDR_W-1:0];
        old    = ref_mem[a];
        refuse = 1'b1;
        do_xfer("refused write", 1'b1, a, ~old, 0, rd, ne);
        check_nack("refused write", 1'b1, ne);
        do_xfer("refused read", 1'b0, a, '0, 0, rd, ne);
        check_nack("refused read", 1'b1, ne);
        refuse = 1'b0;
        read_check("after refusal", a);

        r = $random(seed);
        a = r[ADDR_W-1:0];
        do_xfer("held req", 1'b1, a, r[31:24], HOLD_CYC, rd, ne);
        check_nack("held req", 1'b0, ne);
        ref_mem[a] = r[31:24];

        for (int i = 0; i < 200; i++)
        begin
            r = $random(seed);
            a = r[ADDR_W-1:0];
            if (r[16])
                write_byte("mix write", a, r[31:24]);
            else
                read_check("mix read", a);
        end

        run_ok = 1'b1;
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
hw/eeprom_pkg.sv
hw/i2c_byte_tx.sv
hw/i2c_byte_rx.sv
hw/eeprom_seq.sv
hw/eeprom_ctrl.sv
tb/tb_clock.sv
tb/eeprom_model.sv
tb/eeprom_ctrl_assert.sv
tb/tb_eeprom_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# build and run the eeprom controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f \
    --top-module tb_eeprom_ctrl -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
